/* logic/ddr_stripe_pkg.sv */
package ddr_stripe_pkg;

    // ============================================================
    // Channel geometry
    // ============================================================

    // Number of memory channels a user beat is striped across
    localparam int N_DDR_CHAN = 4;

    // One channel word and its byte enables
    localparam int LANE_BITS = 32;
    localparam int LANE_KEEP = LANE_BITS / 8;

    // The user beat is one lane per channel
    localparam int USER_BITS = N_DDR_CHAN * LANE_BITS;
    localparam int USER_KEEP = N_DDR_CHAN * LANE_KEEP;

    // ============================================================
    // User beat views
    // ============================================================

    // The same user word seen flat at the top level, or split into
    // channel lanes by the splitter and merger.  Lane 0 sits in the
    // low bits, so lanes[i] maps to flat[i*LANE_BITS +: LANE_BITS]
    typedef union packed {
        logic [USER_BITS-1:0]                  flat;
        logic [N_DDR_CHAN-1:0][LANE_BITS-1:0]  lanes;
    } ddr_user_word_u;

endpackage

/* logic/axis_if.sv */
`timescale 1ns/10ps

interface axis_if;

    // One channel lane of an AXI4-Stream link
    logic                                 tvalid;
    logic                                 tready;
    logic [ddr_stripe_pkg::LANE_BITS-1:0] tdata;
    logic [ddr_stripe_pkg::LANE_KEEP-1:0] tkeep;
    logic                                 tlast;

    // Side that drives the beat
    modport src (
        output tvalid,
        output tdata,
        output tkeep,
        output tlast,
        input  tready
    );

    // Side that takes the beat
    modport snk (
        input  tvalid,
        input  tdata,
        input  tkeep,
        input  tlast,
        output tready
    );

endinterface

/* logic/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic aclk,
    input  logic rst_n,

    axis_if.snk  in,
    axis_if.src  out
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    // Storage with one entry per beat
    logic [ddr_stripe_pkg::LANE_BITS-1:0] mem_data [FIFO_DEPTH];
    logic [ddr_stripe_pkg::LANE_KEEP-1:0] mem_keep [FIFO_DEPTH];
    logic                                 mem_last [FIFO_DEPTH];

    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count == CNT_BITS'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign wr_en = in.tvalid & in.tready;
    assign rd_en = out.tvalid & out.tready;

    assign in.tready  = ~full;
    assign out.tvalid = ~empty;

    // Head entry is visible before it is read
    assign out.tdata = mem_data[rd_ptr];
    assign out.tkeep = mem_keep[rd_ptr];
    assign out.tlast = mem_last[rd_ptr];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in.tdata;
            mem_keep[wr_ptr] <= in.tkeep;
            mem_last[wr_ptr] <= in.tlast;
        end
    end

    // Pointers wrap explicitly so that any depth works
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                if (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + PTR_BITS'(1);
                end
            end
            if (rd_en) begin
                if (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + PTR_BITS'(1);
                end
            end
            if (wr_en && !rd_en) begin
                count <= count + CNT_BITS'(1);
            end else if (rd_en && !wr_en) begin
                count <= count - CNT_BITS'(1);
            end
        end
    end

endmodule

/* logic/stripe_splitter.sv */
`timescale 1ns/10ps

module stripe_splitter (
    input  logic                                  user_tvalid,
    output logic                                  user_tready,
    input  ddr_stripe_pkg::ddr_user_word_u        user_tdata,
    input  logic [ddr_stripe_pkg::USER_KEEP-1:0]  user_tkeep,

    axis_if.src                                   lane [ddr_stripe_pkg::N_DDR_CHAN]
);

    localparam int N_CHAN    = ddr_stripe_pkg::N_DDR_CHAN;
    localparam int LANE_KEEP = ddr_stripe_pkg::LANE_KEEP;

    logic [N_CHAN-1:0] lane_ready;
    logic              push;

    // The beat goes out only when every channel can take its lane
    assign user_tready = &lane_ready;
    assign push        = user_tvalid & user_tready;

    for (genvar i = 0; i < N_CHAN; i++) begin : g_lane
        assign lane_ready[i] = lane[i].tready;

        assign lane[i].tvalid = push;
        assign lane[i].tdata  = user_tdata.lanes[i];
        assign lane[i].tkeep  = user_tkeep[i*LANE_KEEP +: LANE_KEEP];

        // Memory channels carry no packet framing
        assign lane[i].tlast  = 1'b0;
    end

endmodule

/* logic/stripe_merger.sv */
`timescale 1ns/10ps

module stripe_merger (
    axis_if.snk                                   lane [ddr_stripe_pkg::N_DDR_CHAN],

    output logic                                  user_tvalid,
    input  logic                                  user_tready,
    output ddr_stripe_pkg::ddr_user_word_u        user_tdata,
    output logic [ddr_stripe_pkg::USER_KEEP-1:0]  user_tkeep,

    output logic                                  fire
);

    localparam int N_CHAN    = ddr_stripe_pkg::N_DDR_CHAN;
    localparam int LANE_KEEP = ddr_stripe_pkg::LANE_KEEP;

    logic [N_CHAN-1:0] lane_valid;

    // A user beat exists only once every channel has returned its word
    assign user_tvalid = &lane_valid;
    assign fire        = user_tvalid & user_tready;

    for (genvar i = 0; i < N_CHAN; i++) begin : g_lane
        assign lane_valid[i] = lane[i].tvalid;

        // All lanes pop together so that none runs ahead of the others
        assign lane[i].tready = fire;

        assign user_tdata.lanes[i]                      = lane[i].tdata;
        assign user_tkeep[i*LANE_KEEP +: LANE_KEEP]     = lane[i].tkeep;
    end

endmodule

/* logic/stripe_ctrl.sv */
`timescale 1ns/10ps

module stripe_ctrl #(
    parameter int LEN_BITS = 8
) (
    input  logic                aclk,
    input  logic                rst_n,

    input  logic                fire,
    input  logic [LEN_BITS-1:0] rd_len,

    output logic                last,
    output logic                busy
);

    logic [LEN_BITS-1:0] beat_cnt;
    logic [LEN_BITS-1:0] len_eff;

    // A zero length would never close a packet, so it reads as one
    assign len_eff = (rd_len == '0) ? LEN_BITS'(1) : rd_len;

    assign last = (beat_cnt == len_eff - LEN_BITS'(1));
    assign busy = (beat_cnt != '0);

    // ============================================================
    // Read beat counter
    // ============================================================

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (fire) begin
            if (last) begin
                beat_cnt <= '0;
            end else begin
                beat_cnt <= beat_cnt + LEN_BITS'(1);
            end
        end
    end

endmodule

/* logic/ddr_stripe_top.sv */
`timescale 1ns/10ps

module ddr_stripe_top #(
    parameter int FIFO_DEPTH = 4,
    parameter int LEN_BITS   = 8
) (
    input  logic                                                    aclk,
    input  logic                                                    rst_n,

    input  logic [LEN_BITS-1:0]                                     rd_len,

    // User write stream
    input  logic                                                    in_tvalid,
    output logic                                                    in_tready,
    input  logic [ddr_stripe_pkg::USER_BITS-1:0]                    in_tdata,
    input  logic [ddr_stripe_pkg::USER_KEEP-1:0]                    in_tkeep,
    input  logic                                                    in_tlast,

    // User read stream
    output logic                                                    out_tvalid,
    input  logic                                                    out_tready,
    output logic [ddr_stripe_pkg::USER_BITS-1:0]                    out_tdata,
    output logic [ddr_stripe_pkg::USER_KEEP-1:0]                    out_tkeep,
    output logic                                                    out_tlast,

    output logic                                                    busy,

    // Card side with lane i in slice i
    output logic [ddr_stripe_pkg::N_DDR_CHAN-1:0]                   card_out_tvalid,
    input  logic [ddr_stripe_pkg::N_DDR_CHAN-1:0]                   card_out_tready,
    output logic [ddr_stripe_pkg::N_DDR_CHAN*ddr_stripe_pkg::LANE_BITS-1:0] card_out_tdata,
    output logic [ddr_stripe_pkg::N_DDR_CHAN*ddr_stripe_pkg::LANE_KEEP-1:0] card_out_tkeep,

    input  logic [ddr_stripe_pkg::N_DDR_CHAN-1:0]                   card_in_tvalid,
    output logic [ddr_stripe_pkg::N_DDR_CHAN-1:0]                   card_in_tready,
    input  logic [ddr_stripe_pkg::N_DDR_CHAN*ddr_stripe_pkg::LANE_BITS-1:0] card_in_tdata,
    input  logic [ddr_stripe_pkg::N_DDR_CHAN*ddr_stripe_pkg::LANE_KEEP-1:0] card_in_tkeep
);

    localparam int N_CHAN    = ddr_stripe_pkg::N_DDR_CHAN;
    localparam int LANE_BITS = ddr_stripe_pkg::LANE_BITS;
    localparam int LANE_KEEP = ddr_stripe_pkg::LANE_KEEP;

    ddr_stripe_pkg::ddr_user_word_u in_word;
    ddr_stripe_pkg::ddr_user_word_u out_word;
    logic                           merge_fire;

    axis_if sink_in  [N_CHAN] ();
    axis_if card_out [N_CHAN] ();
    axis_if card_in  [N_CHAN] ();
    axis_if src_out  [N_CHAN] ();

    // in_tlast is dropped here; framing is rebuilt on the read side from rd_len
    assign in_word.flat = in_tdata;
    assign out_tdata    = out_word.flat;

    // ============================================================
    // Write side
    // ============================================================

    stripe_splitter u_splitter (
        .user_tvalid (in_tvalid),
        .user_tready (in_tready),
        .user_tdata  (in_word),
        .user_tkeep  (in_tkeep),
        .lane        (sink_in)
    );

    for (genvar i = 0; i < N_CHAN; i++) begin : g_chan
        stream_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_sink_fifo (
            .aclk  (aclk),
            .rst_n (rst_n),
            .in    (sink_in[i]),
            .out   (card_out[i])
        );

        assign card_out_tvalid[i]                         = card_out[i].tvalid;
        assign card_out_tdata[i*LANE_BITS +: LANE_BITS]   = card_out[i].tdata;
        assign card_out_tkeep[i*LANE_KEEP +: LANE_KEEP]   = card_out[i].tkeep;
        assign card_out[i].tready                         = card_out_tready[i];

        // Returning words carry no framing either
        assign card_in[i].tvalid = card_in_tvalid[i];
        assign card_in[i].tdata  = card_in_tdata[i*LANE_BITS +: LANE_BITS];
        assign card_in[i].tkeep  = card_in_tkeep[i*LANE_KEEP +: LANE_KEEP];
        assign card_in[i].tlast  = 1'b0;
        assign card_in_tready[i] = card_in[i].tready;

        stream_fifo #(
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_src_fifo (
            .aclk  (aclk),
            .rst_n (rst_n),
            .in    (card_in[i]),
            .out   (src_out[i])
        );
    end

    // ============================================================
    // Read side
    // ============================================================

    stripe_merger u_merger (
        .lane        (src_out),
        .user_tvalid (out_tvalid),
        .user_tready (out_tready),
        .user_tdata  (out_word),
        .user_tkeep  (out_tkeep),
        .fire        (merge_fire)
    );

    stripe_ctrl #(
        .LEN_BITS (LEN_BITS)
    ) u_ctrl (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .fire   (merge_fire),
        .rd_len (rd_len),
        .last   (out_tlast),
        .busy   (busy)
    );

endmodule

/* testbench/stripe_checker.sv */
`timescale 1ns/10ps

module stripe_checker #(
    parameter int LEN_BITS = 8
) (
    input  logic                                 aclk,
    input  logic                                 rst_n,
    input  logic [LEN_BITS-1:0]                  rd_len,

    input  logic                                 in_tvalid,
    input  logic                                 in_tready,
    input  logic [ddr_stripe_pkg::USER_BITS-1:0] in_tdata,
    input  logic [ddr_stripe_pkg::USER_KEEP-1:0] in_tkeep,

    input  logic                                 out_tvalid,
    input  logic                                 out_tready,
    input  logic [ddr_stripe_pkg::USER_BITS-1:0] out_tdata,
    input  logic [ddr_stripe_pkg::USER_KEEP-1:0] out_tkeep,
    input  logic                                 out_tlast,

    output int                                   err_count,
    output int                                   pending,
    output int                                   checked
);

    localparam int USER_BITS = ddr_stripe_pkg::USER_BITS;
    localparam int USER_KEEP = ddr_stripe_pkg::USER_KEEP;
    localparam int BEAT_BITS = USER_KEEP + USER_BITS;

    // Name of the running test, written by the testbench top
    string test_name = "none";

    // Accepted user beats with keep above data
    logic [BEAT_BITS-1:0] sent [$];
    int                   frame_pos;

    // A striped beat comes back unchanged in data and keep
    // The read side closes a packet on every len-th beat
    function automatic logic [BEAT_BITS:0] expected_beat(
        input logic [BEAT_BITS-1:0] in_beat,
        input int                   pos,
        input int                   len
    );
        logic last;
        last = (pos == len - 1);
        return {last, in_beat};
    endfunction

    always @(posedge aclk) begin : compare
        logic [BEAT_BITS:0] exp_beat;
        int                 len;
        len = (rd_len == '0) ? 1 : int'(rd_len);
        if (!rst_n) begin
            sent.delete();
            frame_pos = 0;
        end else begin
            if (out_tvalid && out_tready) begin
                if (sent.size() == 0) begin
                    err_count++;
                    $display("%s: output beat arrived with no input beat waiting for it",
                             test_name);
                end else begin
                    exp_beat = expected_beat(sent.pop_front(), frame_pos, len);
                    checked++;
                    if (out_tdata !== exp_beat[USER_BITS-1:0]) begin
                        err_count++;
                        $display("ERR %s tdata expected %h actual %h", test_name,
                                 exp_beat[USER_BITS-1:0], out_tdata);
                    end
                    if (out_tkeep !== exp_beat[BEAT_BITS-1:USER_BITS]) begin
                        err_count++;
                        $display("ERR %s tkeep expected %h actual %h", test_name,
                                 exp_beat[BEAT_BITS-1:USER_BITS], out_tkeep);
                    end
                    if (out_tlast !== exp_beat[BEAT_BITS]) begin
                        err_count++;
                        $display("ERR %s tlast expected %b actual %b", test_name,
                                 exp_beat[BEAT_BITS], out_tlast);
                    end
                end
                frame_pos = (frame_pos + 1) % len;
            end
            if (in_tvalid && in_tready) begin
                sent.push_back({in_tkeep, in_tdata});
            end
        end
        pending = sent.size();
    end

endmodule

/* testbench/stripe_assertions.sv */
`timescale 1ns/10ps

module stripe_assertions (
    input logic                                  aclk,
    input logic                                  rst_n,
    input logic                                  in_tvalid,
    input logic                                  in_tready,
    input logic                                  out_tvalid,
    input logic                                  out_tready,
    input logic [ddr_stripe_pkg::USER_BITS-1:0]  out_tdata,
    input logic [ddr_stripe_pkg::N_DDR_CHAN-1:0] card_out_tvalid,
    input logic                                  busy
);

    int fail_count = 0;

    // A stalled user beat stays put until it transfers
    out_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        out_tvalid && !out_tready |=> out_tvalid && $stable(out_tdata))
        else begin
            fail_count++;
            $error("user output beat changed while stalled");
        end

    reset_idle: assert property (@(posedge aclk)
        !rst_n |-> !out_tvalid && (card_out_tvalid == '0) && !busy)
        else begin
            fail_count++;
            $error("valid or busy high during reset");
        end

    // Sink FIFOs show a new word one cycle after the user beat is taken
    card_from_user: assert property (@(posedge aclk) disable iff (!rst_n)
        (card_out_tvalid & ~$past(card_out_tvalid)) != '0 |-> $past(in_tvalid && in_tready))
        else begin
            fail_count++;
            $error("card output beat appeared without an accepted user beat");
        end

endmodule

bind ddr_stripe_top stripe_assertions u_assertions (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .in_tvalid       (in_tvalid),
    .in_tready       (in_tready),
    .out_tvalid      (out_tvalid),
    .out_tready      (out_tready),
    .out_tdata       (out_tdata),
    .card_out_tvalid (card_out_tvalid),
    .busy            (busy)
);

/* testbench/tb_ddr_stripe.sv */
`timescale 1ns/10ps

module tb_ddr_stripe;

    localparam int FIFO_DEPTH = 4;
    localparam int LEN_BITS   = 8;
    localparam int N_CHAN     = ddr_stripe_pkg::N_DDR_CHAN;
    localparam int LANE_BITS  = ddr_stripe_pkg::LANE_BITS;
    localparam int LANE_KEEP  = ddr_stripe_pkg::LANE_KEEP;
    localparam int USER_BITS  = ddr_stripe_pkg::USER_BITS;
    localparam int USER_KEEP  = ddr_stripe_pkg::USER_KEEP;

    // Beat counts and read lengths of the tests
    localparam int LANE_BEATS  = 16;
    localparam int SKEW_BEATS  = 64;
    localparam int SKEW_LEN    = 4;
    localparam int FRAME_BEATS = 20;
    localparam int FRAME_LEN   = 5;
    localparam int BP_BEATS    = 32;
    localparam int BP_LEN      = 8;
    localparam int TOTAL_BEATS = 1 + LANE_BEATS + SKEW_BEATS + FRAME_BEATS + BP_BEATS;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic                          aclk;
    logic                          rst_n;
    logic [LEN_BITS-1:0]           rd_len;
    logic                          in_tvalid;
    logic                          in_tready;
    logic [USER_BITS-1:0]          in_tdata;
    logic [USER_KEEP-1:0]          in_tkeep;
    logic                          in_tlast;
    logic                          out_tvalid;
    logic                          out_tready;
    logic [USER_BITS-1:0]          out_tdata;
    logic [USER_KEEP-1:0]          out_tkeep;
    logic                          out_tlast;
    logic                          busy;
    logic [N_CHAN-1:0]             card_out_tvalid;
    logic [N_CHAN-1:0]             card_out_tready;
    logic [N_CHAN*LANE_BITS-1:0]   card_out_tdata;
    logic [N_CHAN*LANE_KEEP-1:0]   card_out_tkeep;
    logic [N_CHAN-1:0]             card_in_tvalid;
    logic [N_CHAN-1:0]             card_in_tready;
    logic [N_CHAN*LANE_BITS-1:0]   card_in_tdata;
    logic [N_CHAN*LANE_KEEP-1:0]   card_in_tkeep;

    logic [15:0] stim_lfsr;
    logic [15:0] loop_lfsr;
    logic        card_stall_en;
    logic        out_stall_en;
    string       test_name;
    int          tb_errors;
    int          tests_run;
    int          tests_failed;
    int          errs_at_start;
    int          in_stall_cycles;
    int          chk_errors;
    int          chk_pending;
    int          chk_checked;

    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    ddr_stripe_top #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .LEN_BITS   (LEN_BITS)
    ) u_ddr_stripe_top (
        .aclk (aclk), .rst_n (rst_n), .rd_len (rd_len),
        .in_tvalid (in_tvalid), .in_tready (in_tready), .in_tdata (in_tdata),
        .in_tkeep (in_tkeep), .in_tlast (in_tlast),
        .out_tvalid (out_tvalid), .out_tready (out_tready), .out_tdata (out_tdata),
        .out_tkeep (out_tkeep), .out_tlast (out_tlast), .busy (busy),
        .card_out_tvalid (card_out_tvalid), .card_out_tready (card_out_tready),
        .card_out_tdata (card_out_tdata), .card_out_tkeep (card_out_tkeep),
        .card_in_tvalid (card_in_tvalid), .card_in_tready (card_in_tready),
        .card_in_tdata (card_in_tdata), .card_in_tkeep (card_in_tkeep)
    );

    stripe_checker #(
        .LEN_BITS (LEN_BITS)
    ) u_checker (
        .aclk (aclk), .rst_n (rst_n), .rd_len (rd_len),
        .in_tvalid (in_tvalid), .in_tready (in_tready), .in_tdata (in_tdata),
        .in_tkeep (in_tkeep),
        .out_tvalid (out_tvalid), .out_tready (out_tready), .out_tdata (out_tdata),
        .out_tkeep (out_tkeep), .out_tlast (out_tlast),
        .err_count (chk_errors), .pending (chk_pending), .checked (chk_checked)
    );

    // ============================================================
    // Random bits
    // ============================================================

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(inout logic [15:0] s, input int n,
                             output logic [USER_BITS-1:0] bits);
        bits = '0;
        for (int k = 0; k < n; k++) begin
            s = lfsr_step(s);
            bits[k] = s[0];
        end
    endtask

    // ============================================================
    // Card loopback with one holding word per channel
    // ============================================================

    always begin : loopback
        logic [N_CHAN-1:0]           in_fire;
        logic [N_CHAN-1:0]           out_fire;
        logic [N_CHAN*LANE_BITS-1:0] out_data;
        logic [N_CHAN*LANE_KEEP-1:0] out_keep;
        logic [USER_BITS-1:0]        stall;
        @(posedge aclk);
        in_fire  = card_in_tvalid & card_in_tready;
        out_fire = card_out_tvalid & card_out_tready;
        out_data = card_out_tdata;
        out_keep = card_out_tkeep;
        #2;
        draw_bits(loop_lfsr, N_CHAN + 1, stall);
        for (int i = 0; i < N_CHAN; i++) begin
            if (!rst_n || in_fire[i]) begin
                card_in_tvalid[i] = 1'b0;
            end
            if (rst_n && out_fire[i]) begin
                card_in_tvalid[i] = 1'b1;
                card_in_tdata[i*LANE_BITS +: LANE_BITS] = out_data[i*LANE_BITS +: LANE_BITS];
                card_in_tkeep[i*LANE_KEEP +: LANE_KEEP] = out_keep[i*LANE_KEEP +: LANE_KEEP];
            end
            card_out_tready[i] = !card_in_tvalid[i] && !(card_stall_en && stall[i]);
        end
        out_tready = !(out_stall_en && stall[N_CHAN]);
    end

    // ============================================================
    // Stimulus and test flow
    // ============================================================

    function automatic int total_errors();
        return tb_errors + chk_errors + u_ddr_stripe_top.u_assertions.fail_count;
    endfunction

    task automatic send_beat(input logic [USER_BITS-1:0] data,
                             input logic [USER_KEEP-1:0] keep);
        logic accepted;
        in_tvalid = 1'b1;
        in_tdata  = data;
        in_tkeep  = keep;
        accepted  = 1'b0;
        while (!accepted) begin
            @(posedge aclk);
            accepted = in_tready;
            if (!in_tready) begin
                in_stall_cycles++;
            end
            #2;
        end
        in_tvalid = 1'b0;
    endtask

    task automatic send_random(input int n);
        logic [USER_BITS-1:0] data;
        logic [USER_BITS-1:0] keep;
        for (int b = 0; b < n; b++) begin
            draw_bits(stim_lfsr, USER_BITS, data);
            draw_bits(stim_lfsr, USER_KEEP, keep);
            send_beat(data, keep[USER_KEEP-1:0]);
        end
    endtask

    // Every lane word carries its lane number and the beat number
    task automatic send_tagged(input int n);
        logic [USER_BITS-1:0] data;
        for (int b = 0; b < n; b++) begin
            for (int i = 0; i < N_CHAN; i++) begin
                data[i*LANE_BITS +: LANE_BITS] = {8'h5a, 8'(i), 16'(b)};
            end
            send_beat(data, '1);
        end
    endtask

    task automatic wait_drained();
        do begin
            @(posedge aclk);
            #2;
        end while (chk_pending != 0);
        if (busy !== 1'b0) begin
            tb_errors++;
            $display("%s: busy still high after the final beat", test_name);
        end
    endtask

    task automatic check_idle(input string where);
        if (out_tvalid !== 1'b0 || card_out_tvalid !== '0 || busy !== 1'b0) begin
            tb_errors++;
            $display("%s: a valid or busy output is high %s", test_name, where);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        u_checker.test_name = name;
        errs_at_start = total_errors();
    endtask

    task automatic end_test();
        int errs;
        errs = total_errors() - errs_at_start;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    initial begin : main
        rst_n = 1'b0;
        rd_len = LEN_BITS'(1);
        in_tvalid = 1'b0;
        in_tdata = '0;
        in_tkeep = '0;
        in_tlast = 1'b0;
        out_tready = 1'b1;
        card_out_tready = '0;
        card_in_tvalid = '0;
        card_in_tdata = '0;
        card_in_tkeep = '0;
        stim_lfsr = 16'd1;
        loop_lfsr = 16'd1;
        card_stall_en = 1'b0;
        out_stall_en = 1'b0;

        start_test("reset_state");
        repeat (5) begin
            @(posedge aclk);
            #2;
            check_idle("during reset");
        end
        rst_n = 1'b1;
        @(posedge aclk);
        #2;
        check_idle("right after reset");
        end_test();

        start_test("single_beat");
        send_random(1);
        wait_drained();
        end_test();

        start_test("lane_order");
        card_stall_en = 1'b1;
        send_tagged(LANE_BEATS);
        wait_drained();
        end_test();

        start_test("skewed_channels");
        rd_len = LEN_BITS'(SKEW_LEN);
        send_random(SKEW_BEATS);
        wait_drained();
        end_test();

        start_test("framing");
        rd_len = LEN_BITS'(FRAME_LEN);
        send_random(FRAME_BEATS);
        wait_drained();
        end_test();

        start_test("output_backpressure");
        rd_len = LEN_BITS'(BP_LEN);
        out_stall_en = 1'b1;
        in_stall_cycles = 0;
        send_random(BP_BEATS);
        out_stall_en = 1'b0;
        wait_drained();
        if (in_stall_cycles == 0) begin
            tb_errors++;
            $display("%s: in_tready never fell while the output was stalled", test_name);
        end
        end_test();

        $display("tests run %0d, failed %0d, errors %0d, beats checked %0d",
                 tests_run, tests_failed, total_errors(), chk_checked);
        if (total_errors() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("timeout: test %s did not finish within %0d cycles",
                 test_name, WATCHDOG_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* flist.f */
logic/ddr_stripe_pkg.sv
logic/axis_if.sv
logic/stream_fifo.sv
logic/stripe_splitter.sv
logic/stripe_merger.sv
logic/stripe_ctrl.sv
logic/ddr_stripe_top.sv
testbench/stripe_checker.sv
testbench/stripe_assertions.sv
testbench/tb_ddr_stripe.sv

/* Bender.yml */
package:
  name: ddr_stripe

sources:
  - logic/ddr_stripe_pkg.sv
  - logic/axis_if.sv
  - logic/stream_fifo.sv
  - logic/stripe_splitter.sv
  - logic/stripe_merger.sv
  - logic/stripe_ctrl.sv
  - logic/ddr_stripe_top.sv
  - target: test
    files:
      - testbench/stripe_checker.sv
      - testbench/stripe_assertions.sv
      - testbench/tb_ddr_stripe.sv
